/* design/key_extract_pkg.sv */
`default_nettype none

package key_extract_pkg;

	// ============================================================
	// control stream
	// ============================================================
	localparam int ctrl_data_w = 256;
	localparam int ctrl_user_w = 128;
	localparam int ctrl_keep_w = 32;

	// which extractor this stage answers to
	localparam logic [4:0] stage_id = 5'd0;
	localparam logic [2:0] key_ex_id = 3'd1;
	localparam logic [15:0] ctrl_flag = 16'hf2f1;

	// header field positions in the raw second beat
	localparam int flag_lsb = 64;
	localparam int mod_id_lsb = 112;
	localparam int resv_lsb = 120;
	localparam int index_lsb = 128;

	// ============================================================
	// phv and table geometry
	// ============================================================
	localparam int cont_num = 8;
	localparam int w6 = 48;
	localparam int w4 = 32;
	localparam int w2 = 16;
	localparam int meta_w = 32;

	localparam int sel_w = 3;
	localparam int tab_depth = 32;
	localparam int tab_addr_w = 5;
	localparam int vlan_w = 12;
	localparam int vlan_addr_lsb = 4;

	typedef struct packed {
		logic [ctrl_data_w-1:0] data;
		logic [ctrl_user_w-1:0] user;
		logic [ctrl_keep_w-1:0] keep;
		logic last;
		logic valid;
	} ctrl_beat_t;

	typedef struct packed {
		logic [4:0] stage;
		logic [2:0] ext;
	} mod_id_t;

	// second beat as seen by the parser, msb first
	typedef struct packed {
		logic [ctrl_data_w-index_lsb-9:0] pad_hi;
		logic [7:0] index;
		logic [index_lsb-resv_lsb-5:0] pad_resv;
		logic [3:0] resv;
		mod_id_t mod_id;
		logic [mod_id_lsb-flag_lsb-17:0] pad_mid;
		logic [15:0] flag;
		logic [flag_lsb-1:0] pad_lo;
	} ctrl_hdr_t;

	typedef union packed {
		logic [ctrl_data_w-1:0] raw;
		ctrl_hdr_t hdr;
	} ctrl_word_u;

	typedef struct packed {
		logic [cont_num-1:0][w6-1:0] c6;
		logic [cont_num-1:0][w4-1:0] c4;
		logic [cont_num-1:0][w2-1:0] c2;
		logic [meta_w-1:0] meta;
	} phv_t;

	typedef struct packed {
		logic [sel_w-1:0] s6a;
		logic [sel_w-1:0] s6b;
		logic [sel_w-1:0] s4a;
		logic [sel_w-1:0] s4b;
		logic [sel_w-1:0] s2a;
		logic [sel_w-1:0] s2b;
	} key_off_t;

	typedef struct packed {
		logic [w6-1:0] k6a;
		logic [w6-1:0] k6b;
		logic [w4-1:0] k4a;
		logic [w4-1:0] k4b;
		logic [w2-1:0] k2a;
		logic [w2-1:0] k2b;
	} key_t;

	typedef logic [tab_addr_w-1:0] tab_addr_t;

endpackage

`default_nettype wire

/* design/ctrl_table_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrl_table_fsm (
	input logic clk,
	input logic rst_n,
	input key_extract_pkg::ctrl_beat_t ctrl_in,
	output key_extract_pkg::ctrl_beat_t ctrl_out,
	output logic index_load,
	output logic [7:0] load_index,
	output logic entry_strobe,
	output key_extract_pkg::ctrl_word_u entry_word
);

	typedef enum logic [1:0] {
		st_idle,
		st_parse,
		st_write_entries,
		st_flush
	} state_t;

	state_t state;
	state_t state_next;

	key_extract_pkg::ctrl_beat_t first_beat;
	key_extract_pkg::ctrl_beat_t ctrl_d1;
	key_extract_pkg::ctrl_beat_t out_next;
	key_extract_pkg::ctrl_word_u in_word;
	logic capture_first;
	logic hdr_match;

	// ============================================================
	// header decode on the live beat
	// ============================================================
	assign in_word = ctrl_in.data;

	assign hdr_match = (in_word.hdr.flag == key_extract_pkg::ctrl_flag) &&
		(in_word.hdr.mod_id.stage == key_extract_pkg::stage_id) &&
		(in_word.hdr.mod_id.ext == key_extract_pkg::key_ex_id) &&
		(in_word.hdr.resv == '0);

	// strobes qualify these, so they can follow the input freely
	assign load_index = in_word.hdr.index;
	assign entry_word = in_word;

	// ============================================================
	// next state
	// ============================================================
	always_comb begin
		state_next = state;
		out_next = '0;
		capture_first = 1'b0;
		index_load = 1'b0;
		entry_strobe = 1'b0;

		case (state)
			st_idle: begin
				if (ctrl_in.valid) begin
					if (ctrl_in.last) begin
						// single beat, nothing to parse
						out_next = ctrl_in;
					end else begin
						capture_first = 1'b1;
						state_next = st_parse;
					end
				end
			end
			st_parse: begin
				if (ctrl_in.valid) begin
					if (hdr_match) begin
						index_load = 1'b1;
						state_next = ctrl_in.last ? st_idle : st_write_entries;
					end else begin
						// not ours, replay the held first beat
						out_next = first_beat;
						state_next = st_flush;
					end
				end
			end
			st_write_entries: begin
				if (ctrl_in.valid) begin
					entry_strobe = 1'b1;
					if (ctrl_in.last) begin
						state_next = st_idle;
					end
				end
			end
			st_flush: begin
				out_next = ctrl_d1;
				if (ctrl_d1.valid && ctrl_d1.last) begin
					state_next = st_idle;
					// next packet may already be here
					if (ctrl_in.valid) begin
						if (ctrl_in.last) begin
							state_next = st_flush;
						end else begin
							capture_first = 1'b1;
							state_next = st_parse;
						end
					end
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			ctrl_out <= '0;
			ctrl_d1 <= '0;
		end else begin
			state <= state_next;
			ctrl_out <= out_next;
			ctrl_d1 <= ctrl_in;
		end
	end

	// first beat held until the header decides
	always_ff @(posedge clk) begin
		if (capture_first) begin
			first_beat <= ctrl_in;
		end
	end

endmodule

`default_nettype wire

/* design/table_write_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module table_write_counter (
	input logic clk,
	input logic rst_n,
	input logic index_load,
	input logic [7:0] load_index,
	input logic entry_strobe,
	input key_extract_pkg::ctrl_word_u entry_word,
	output logic tab_wr,
	output key_extract_pkg::tab_addr_t tab_addr,
	output key_extract_pkg::key_off_t tab_data
);

	key_extract_pkg::tab_addr_t wr_index;
	logic [key_extract_pkg::ctrl_data_w-1:0] swapped;

	// entries arrive little endian, table wants big endian
	always_comb begin
		for (int b = 0; b < key_extract_pkg::ctrl_data_w / 8; b++) begin
			swapped[key_extract_pkg::ctrl_data_w-1-8*b -: 8] = entry_word.raw[8*b +: 8];
		end
	end

	// index wraps at table depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_index <= '0;
			tab_wr <= 1'b0;
		end else begin
			tab_wr <= entry_strobe;
			if (index_load) begin
				wr_index <= key_extract_pkg::tab_addr_t'(load_index);
			end else if (entry_strobe) begin
				wr_index <= wr_index + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (entry_strobe) begin
			tab_addr <= wr_index;
			tab_data <= key_extract_pkg::key_off_t'(
				swapped[key_extract_pkg::ctrl_data_w-1 -: $bits(key_extract_pkg::key_off_t)]);
		end
	end

endmodule

`default_nettype wire

/* design/offset_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module offset_ram (
	input logic clk,
	input logic wr,
	input key_extract_pkg::tab_addr_t wr_addr,
	input key_extract_pkg::key_off_t wr_data,
	input logic rd_en,
	input key_extract_pkg::tab_addr_t rd_addr,
	output key_extract_pkg::key_off_t rd_data
);

	key_extract_pkg::key_off_t mem [key_extract_pkg::tab_depth];

	// empty table selects container 0 everywhere
	initial begin
		for (int i = 0; i < key_extract_pkg::tab_depth; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read before write on a shared address
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

/* design/key_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module key_builder (
	input logic clk,
	input logic rst_n,
	input key_extract_pkg::phv_t phv_in,
	input logic phv_valid_in,
	input logic vlan_in_valid,
	input logic ready_in,
	input key_extract_pkg::key_off_t rd_data,
	output logic rd_en,
	output key_extract_pkg::phv_t phv_out,
	output logic phv_valid_out,
	output key_extract_pkg::key_t key_out,
	output logic key_valid_out
);

	key_extract_pkg::phv_t phv_d1;
	key_extract_pkg::key_t key_next;
	logic valid_d1;
	logic valid_d2;

	// ram read register moves in step with stage 1
	assign rd_en = ready_in;

	// ============================================================
	// stage 1 valid and stage 2 valid
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else if (ready_in) begin
			valid_d1 <= phv_valid_in && vlan_in_valid;
			valid_d2 <= valid_d1;
		end
	end

	// selectors arrive together with phv_d1
	always_comb begin
		key_next.k6a = phv_d1.c6[rd_data.s6a];
		key_next.k6b = phv_d1.c6[rd_data.s6b];
		key_next.k4a = phv_d1.c4[rd_data.s4a];
		key_next.k4b = phv_d1.c4[rd_data.s4b];
		key_next.k2a = phv_d1.c2[rd_data.s2a];
		key_next.k2b = phv_d1.c2[rd_data.s2b];
	end

	always_ff @(posedge clk) begin
		if (ready_in) begin
			phv_d1 <= phv_in;
			phv_out <= phv_d1;
			key_out <= key_next;
		end
	end

	// phv and key leave as one
	assign phv_valid_out = valid_d2;
	assign key_valid_out = valid_d2;

endmodule

`default_nettype wire

/* design/key_extract_top.sv */
`timescale 1ns/100ps
`default_nettype none

module key_extract_top (
	input logic clk,
	input logic rst_n,
	input key_extract_pkg::phv_t phv_in,
	input logic phv_valid_in,
	output logic ready_out,
	input logic [key_extract_pkg::vlan_w-1:0] vlan_in,
	input logic vlan_in_valid,
	output logic vlan_ready,
	output key_extract_pkg::phv_t phv_out,
	output logic phv_valid_out,
	output key_extract_pkg::key_t key_out,
	output logic key_valid_out,
	input logic ready_in,
	input key_extract_pkg::ctrl_beat_t ctrl_in,
	output key_extract_pkg::ctrl_beat_t ctrl_out
);

	logic index_load;
	logic [7:0] load_index;
	logic entry_strobe;
	key_extract_pkg::ctrl_word_u entry_word;
	logic tab_wr;
	key_extract_pkg::tab_addr_t tab_addr;
	key_extract_pkg::key_off_t tab_data;
	logic rd_en;
	key_extract_pkg::tab_addr_t rd_addr;
	key_extract_pkg::key_off_t rd_data;

	assign ready_out = ready_in;
	assign vlan_ready = ready_in;

	// vlan bits 8 to 4 pick the table entry
	assign rd_addr = vlan_in[key_extract_pkg::vlan_addr_lsb +: key_extract_pkg::tab_addr_w];

	// ============================================================
	// control path
	// ============================================================
	ctrl_table_fsm u_fsm (
		.clk (clk),
		.rst_n (rst_n),
		.ctrl_in (ctrl_in),
		.ctrl_out (ctrl_out),
		.index_load (index_load),
		.load_index (load_index),
		.entry_strobe (entry_strobe),
		.entry_word (entry_word)
	);

	table_write_counter u_counter (
		.clk (clk),
		.rst_n (rst_n),
		.index_load (index_load),
		.load_index (load_index),
		.entry_strobe (entry_strobe),
		.entry_word (entry_word),
		.tab_wr (tab_wr),
		.tab_addr (tab_addr),
		.tab_data (tab_data)
	);

	offset_ram u_ram (
		.clk (clk),
		.wr (tab_wr),
		.wr_addr (tab_addr),
		.wr_data (tab_data),
		.rd_en (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// ============================================================
	// data path
	// ============================================================
	key_builder u_builder (
		.clk (clk),
		.rst_n (rst_n),
		.phv_in (phv_in),
		.phv_valid_in (phv_valid_in),
		.vlan_in_valid (vlan_in_valid),
		.ready_in (ready_in),
		.rd_data (rd_data),
		.rd_en (rd_en),
		.phv_out (phv_out),
		.phv_valid_out (phv_valid_out),
		.key_out (key_out),
		.key_valid_out (key_valid_out)
	);

endmodule

`default_nettype wire

/* tests/key_extract_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module key_extract_chk (
	input logic clk,
	input logic rst_n,
	input logic phv_valid_in,
	input logic vlan_in_valid,
	input logic ready_in,
	input key_extract_pkg::phv_t phv_out,
	input logic phv_valid_out,
	input key_extract_pkg::key_t key_out,
	input logic key_valid_out,
	input key_extract_pkg::ctrl_beat_t ctrl_out
);

	// count of failed assertions
	int fail_cnt;

	// phv and key leave under one valid
	valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
		phv_valid_out == key_valid_out)
		else begin
			fail_cnt++;
			$error("phv_valid_out and key_valid_out disagree");
		end

	// stalled stage keeps what it shows
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!ready_in |=> $stable(phv_out) && $stable(key_out) && $stable(phv_valid_out))
		else begin
			fail_cnt++;
			$error("data path outputs moved while ready_in was low");
		end

	vlan_with_phv: assert property (@(posedge clk) disable iff (!rst_n)
		(phv_valid_in || vlan_in_valid) |-> (phv_valid_in == vlan_in_valid))
		else begin
			fail_cnt++;
			$error("vlan_in_valid and phv_valid_in were not driven together");
		end

	ctrl_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !ctrl_out.valid)
		else begin
			fail_cnt++;
			$error("ctrl_out.valid was high on leaving reset");
		end

endmodule

bind key_extract_top key_extract_chk u_chk (.*);

`default_nettype wire

/* tests/tb_key_extract.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_key_extract;

	typedef enum logic [1:0] {
		op_ctrl_write,
		op_ctrl_foreign,
		op_phv_lookup,
		op_stall
	} op_t;

	// count is entries, beats or stall cycles depending on kind
	typedef struct packed {
		op_t kind;
		logic [3:0] test;
		logic [7:0] index;
		logic [7:0] count;
		logic [1:0] bad;
		logic [11:0] vlan;
		logic [31:0] seed;
	} row_t;

	logic clk;
	logic rst_n;
	key_extract_pkg::phv_t phv_in;
	logic phv_valid_in;
	logic ready_out;
	logic [key_extract_pkg::vlan_w-1:0] vlan_in;
	logic vlan_in_valid;
	logic vlan_ready;
	key_extract_pkg::phv_t phv_out;
	logic phv_valid_out;
	key_extract_pkg::key_t key_out;
	logic key_valid_out;
	logic ready_in;
	key_extract_pkg::ctrl_beat_t ctrl_in;
	key_extract_pkg::ctrl_beat_t ctrl_out;

	logic [31:0] rng;
	int checks;
	int errors;
	int tests_run;
	int cycle_cnt;
	int cycle_limit;
	int adv_cnt;

	key_extract_pkg::key_off_t tab_copy [key_extract_pkg::tab_depth];
	key_extract_pkg::phv_t exp_phv_q [$];
	key_extract_pkg::key_t exp_key_q [$];
	key_extract_pkg::ctrl_beat_t exp_ctrl_q [$];
	int stamp_q [$];

	// ============================================================
	// stimulus table
	// ============================================================
	row_t rows [24] = '{
		'{op_ctrl_write, 4'd1, 8'd5, 8'd1, 2'd0, 12'h000, 32'h0},
		'{op_phv_lookup, 4'd1, 8'd0, 8'd0, 2'd0, 12'h053, 32'h11},
		'{op_phv_lookup, 4'd1, 8'd0, 8'd0, 2'd0, 12'h090, 32'h12},
		'{op_ctrl_write, 4'd2, 8'd30, 8'd4, 2'd0, 12'h000, 32'h0},
		'{op_phv_lookup, 4'd2, 8'd0, 8'd0, 2'd0, 12'hfe7, 32'h21},
		'{op_phv_lookup, 4'd2, 8'd0, 8'd0, 2'd0, 12'h3f2, 32'h22},
		'{op_phv_lookup, 4'd2, 8'd0, 8'd0, 2'd0, 12'h60a, 32'h23},
		'{op_phv_lookup, 4'd2, 8'd0, 8'd0, 2'd0, 12'h815, 32'h24},
		'{op_ctrl_foreign, 4'd3, 8'd0, 8'd3, 2'd0, 12'h000, 32'h0},
		'{op_ctrl_foreign, 4'd3, 8'd0, 8'd4, 2'd1, 12'h000, 32'h0},
		'{op_ctrl_foreign, 4'd3, 8'd0, 8'd2, 2'd2, 12'h000, 32'h0},
		'{op_ctrl_foreign, 4'd3, 8'd0, 8'd5, 2'd3, 12'h000, 32'h0},
		'{op_ctrl_foreign, 4'd3, 8'd0, 8'd1, 2'd0, 12'h000, 32'h0},
		'{op_ctrl_write, 4'd3, 8'd12, 8'd2, 2'd0, 12'h000, 32'h0},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h053, 32'h31},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'hfe7, 32'h32},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h3f2, 32'h33},
		'{op_stall, 4'd4, 8'd0, 8'd3, 2'd0, 12'h000, 32'h0},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h60a, 32'h34},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h815, 32'h35},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h0c5, 32'h36},
		'{op_stall, 4'd4, 8'd0, 8'd2, 2'd0, 12'h000, 32'h0},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h090, 32'h37},
		'{op_phv_lookup, 4'd4, 8'd0, 8'd0, 2'd0, 12'h0c5, 32'h38}
	};

	key_extract_top u_dut (
		.clk (clk),
		.rst_n (rst_n),
		.phv_in (phv_in),
		.phv_valid_in (phv_valid_in),
		.ready_out (ready_out),
		.vlan_in (vlan_in),
		.vlan_in_valid (vlan_in_valid),
		.vlan_ready (vlan_ready),
		.phv_out (phv_out),
		.phv_valid_out (phv_valid_out),
		.key_out (key_out),
		.key_valid_out (key_valid_out),
		.ready_in (ready_in),
		.ctrl_in (ctrl_in),
		.ctrl_out (ctrl_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic [255:0] random_word();
		logic [255:0] w;
		for (int i = 0; i < 8; i++) begin
			w[32*i +: 32] = next_rand();
		end
		return w;
	endfunction

	// byte 0 of the wire word is the top byte of the entry word
	function automatic logic [255:0] swap_bytes(input logic [255:0] w);
		logic [255:0] r;
		for (int i = 0; i < 32; i++) begin
			r[8*i +: 8] = w[8*(31-i) +: 8];
		end
		return r;
	endfunction

	function automatic logic [255:0] make_header(input logic [7:0] index,
		input logic [4:0] stage, input logic [2:0] ext, input logic [15:0] flag,
		input logic [3:0] resv);
		logic [255:0] w;
		w = random_word();
		w[key_extract_pkg::flag_lsb +: 16] = flag;
		w[key_extract_pkg::mod_id_lsb +: 8] = {stage, ext};
		w[key_extract_pkg::resv_lsb +: 4] = resv;
		w[key_extract_pkg::index_lsb +: 8] = index;
		return w;
	endfunction

	function automatic key_extract_pkg::ctrl_beat_t make_beat(input logic [255:0] data,
		input logic last);
		key_extract_pkg::ctrl_beat_t b;
		b.data = data;
		for (int i = 0; i < 4; i++) begin
			b.user[32*i +: 32] = next_rand();
		end
		b.keep = next_rand();
		b.last = last;
		b.valid = 1'b1;
		return b;
	endfunction

	// meta carries the row tag
	function automatic key_extract_pkg::phv_t make_phv(input logic [31:0] seed);
		key_extract_pkg::phv_t p;
		logic [31:0] x;
		for (int i = 0; i < key_extract_pkg::cont_num; i++) begin
			x = next_rand();
			p.c6[i][47:32] = x[31:16];
			p.c6[i][31:0] = next_rand();
			p.c4[i] = next_rand();
			x = next_rand();
			p.c2[i] = x[23:8];
		end
		p.meta = seed;
		return p;
	endfunction

	function automatic int row_cycles(input row_t row);
		case (row.kind)
			op_ctrl_write: return row.count + 8;
			op_ctrl_foreign: return row.count + 6;
			op_phv_lookup: return 1;
			default: return row.count + 1;
		endcase
	endfunction

	function automatic string test_name(input logic [3:0] test);
		case (test)
			4'd1: return "single-entry write";
			4'd2: return "multi-entry write";
			4'd3: return "forwarding";
			default: return "back-pressure";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [1023:0] got,
		input logic [1023:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ============================================================
	// row drivers
	// ============================================================
	task automatic write_table_packet(input logic [7:0] index, input int count);
		key_extract_pkg::key_off_t sel;
		logic [31:0] r;
		logic [255:0] fill;
		@(negedge clk);
		phv_valid_in = 1'b0;
		vlan_in_valid = 1'b0;
		ctrl_in = make_beat(random_word(), 1'b0);
		@(negedge clk);
		ctrl_in = make_beat(make_header(index, key_extract_pkg::stage_id,
			key_extract_pkg::key_ex_id, key_extract_pkg::ctrl_flag, 4'h0), count == 0);
		for (int k = 0; k < count; k++) begin
			r = next_rand();
			sel = r[17:0];
			fill = random_word();
			@(negedge clk);
			ctrl_in = make_beat(swap_bytes({sel, fill[237:0]}), k == count - 1);
			tab_copy[(index + k) % key_extract_pkg::tab_depth] = sel;
		end
		@(negedge clk);
		ctrl_in = '0;
		repeat (4) @(negedge clk);
	endtask

	// second beat carries the header with one field spoiled
	task automatic forward_foreign_packet(input int beats, input logic [1:0] bad);
		key_extract_pkg::ctrl_beat_t b;
		logic [255:0] w;
		@(negedge clk);
		phv_valid_in = 1'b0;
		vlan_in_valid = 1'b0;
		for (int k = 0; k < beats; k++) begin
			if (k == 1) begin
				case (bad)
					2'd0: w = make_header(8'd3, key_extract_pkg::stage_id,
						key_extract_pkg::key_ex_id + 3'd1, key_extract_pkg::ctrl_flag, 4'h0);
					2'd1: w = make_header(8'd3, key_extract_pkg::stage_id,
						key_extract_pkg::key_ex_id, key_extract_pkg::ctrl_flag ^ 16'h0100, 4'h0);
					2'd2: w = make_header(8'd3, key_extract_pkg::stage_id,
						key_extract_pkg::key_ex_id, key_extract_pkg::ctrl_flag, 4'h2);
					default: w = make_header(8'd3, key_extract_pkg::stage_id + 5'd1,
						key_extract_pkg::key_ex_id, key_extract_pkg::ctrl_flag, 4'h0);
				endcase
			end else begin
				w = random_word();
			end
			w[15:0] = {8'ha5, 8'(k)};
			b = make_beat(w, k == beats - 1);
			if (k > 0) begin
				@(negedge clk);
			end
			ctrl_in = b;
			exp_ctrl_q.push_back(b);
		end
		@(negedge clk);
		ctrl_in = '0;
		repeat (4) @(negedge clk);
	endtask

	task automatic drive_lookup(input logic [11:0] vlan, input logic [31:0] seed);
		key_extract_pkg::phv_t p;
		key_extract_pkg::key_off_t sel;
		key_extract_pkg::key_t k;
		p = make_phv(seed);
		sel = tab_copy[vlan[8:4]];
		k.k6a = p.c6[sel.s6a];
		k.k6b = p.c6[sel.s6b];
		k.k4a = p.c4[sel.s4a];
		k.k4b = p.c4[sel.s4b];
		k.k2a = p.c2[sel.s2a];
		k.k2b = p.c2[sel.s2b];
		@(negedge clk);
		phv_in = p;
		vlan_in = vlan;
		phv_valid_in = 1'b1;
		vlan_in_valid = 1'b1;
		ready_in = 1'b1;
		exp_phv_q.push_back(p);
		exp_key_q.push_back(k);
	endtask

	task automatic stall_outputs(input int cycles);
		@(negedge clk);
		check_value("ready_out", ready_out, 1'b1);
		check_value("vlan_ready", vlan_ready, 1'b1);
		phv_valid_in = 1'b0;
		vlan_in_valid = 1'b0;
		ready_in = 1'b0;
		repeat (cycles) @(negedge clk);
		check_value("ready_out", ready_out, 1'b0);
		check_value("vlan_ready", vlan_ready, 1'b0);
		ready_in = 1'b1;
	endtask

	task automatic drain_pipeline();
		@(negedge clk);
		phv_valid_in = 1'b0;
		vlan_in_valid = 1'b0;
		while (exp_phv_q.size() != 0 || exp_ctrl_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	// ============================================================
	// monitors
	// ============================================================
	// adv_cnt counts clocks on which the pipeline moves
	always @(posedge clk) begin
		if (rst_n) begin
			if (phv_valid_in && vlan_in_valid && ready_in) begin
				stamp_q.push_back(adv_cnt);
			end
			if (phv_valid_out && ready_in) begin
				if (exp_phv_q.size() == 0) begin
					errors++;
					$display("a PHV left the stage with no lookup waiting for it");
				end else begin
					check_value("phv_out", phv_out, exp_phv_q.pop_front());
					check_value("key_out", key_out, exp_key_q.pop_front());
					check_value("key_valid_out", key_valid_out, 1'b1);
					check_value("lookup latency", adv_cnt - stamp_q.pop_front(), 2);
				end
			end
			if (ready_in) begin
				adv_cnt++;
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && ctrl_out.valid) begin
			if (exp_ctrl_q.size() == 0) begin
				errors++;
				$display("ctrl_out sent a beat that no forwarded packet accounts for");
			end else begin
				check_value("ctrl_out", ctrl_out, exp_ctrl_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the stimulus table did not finish", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		int err_mark;
		rng = 32'h952c;
		cycle_limit = 100;
		foreach (rows[r]) begin
			cycle_limit += 4 * row_cycles(rows[r]);
		end
		foreach (tab_copy[i]) begin
			tab_copy[i] = '0;
		end
		rst_n = 1'b0;
		phv_in = '0;
		phv_valid_in = 1'b0;
		vlan_in = '0;
		vlan_in_valid = 1'b0;
		ready_in = 1'b1;
		ctrl_in = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		check_value("phv_valid_out", phv_valid_out, 1'b0);
		check_value("key_valid_out", key_valid_out, 1'b0);
		check_value("ctrl_out.valid", ctrl_out.valid, 1'b0);
		tests_run++;
		$display("test 0 (reset) finished with %0d errors", errors);
		err_mark = errors;

		for (int r = 0; r < $size(rows); r++) begin
			case (rows[r].kind)
				op_ctrl_write: write_table_packet(rows[r].index, rows[r].count);
				op_ctrl_foreign: forward_foreign_packet(rows[r].count, rows[r].bad);
				op_phv_lookup: drive_lookup(rows[r].vlan, rows[r].seed);
				default: stall_outputs(rows[r].count);
			endcase
			// a test ends where the next row starts another one
			if (r == $size(rows) - 1 || rows[r+1].test != rows[r].test) begin
				drain_pipeline();
				tests_run++;
				$display("test %0d (%s) finished with %0d errors", rows[r].test,
					test_name(rows[r].test), errors - err_mark);
				err_mark = errors;
			end
		end

		errors += u_dut.u_chk.fail_cnt;
		$display("%0d tests, %0d checks, %0d assertion failures, %0d errors", tests_run,
			checks, u_dut.u_chk.fail_cnt, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
design/key_extract_pkg.sv
design/ctrl_table_fsm.sv
design/table_write_counter.sv
design/offset_ram.sv
design/key_builder.sv
design/key_extract_top.sv
tests/key_extract_chk.sv
tests/tb_key_extract.sv

/* Bender.yml */
package:
  name: key_extract

sources:
  - design/key_extract_pkg.sv
  - design/ctrl_table_fsm.sv
  - design/table_write_counter.sv
  - design/offset_ram.sv
  - design/key_builder.sv
  - design/key_extract_top.sv
  - target: test
    files:
      - tests/key_extract_chk.sv
      - tests/tb_key_extract.sv
